// File: hw/cpu_pkg.sv
//////////////////////////////////////////////////
// CPU package
// Word and register index types, opcode encoding,
// the instruction layout, the outside-facing
// structs and the four pipeline stage payloads
//////////////////////////////////////////////////

package cpu_pkg;

	localparam int data_width     = 16;
	localparam int reg_addr_width = 4;

	typedef logic [data_width-1:0]     word_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	// Full 4-bit opcode space
	// RED, PADDSB, B and BR still decode here but do nothing
	typedef enum logic [3:0] {
		op_add    = 4'h0,
		op_sub    = 4'h1,
		op_red    = 4'h2,
		op_xor    = 4'h3,
		op_sll    = 4'h4,
		op_sra    = 4'h5,
		op_ror    = 4'h6,
		op_paddsb = 4'h7,
		op_lw     = 4'h8,
		op_sw     = 4'h9,
		op_lhb    = 4'ha,
		op_llb    = 4'hb,
		op_b      = 4'hc,
		op_br     = 4'hd,
		op_pcs    = 4'he,
		op_hlt    = 4'hf
	} opcode_e;

	// rt doubles as the 4-bit immediate, {rs, rt} as the 8-bit one
	typedef struct packed {
		opcode_e   opcode;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
	} instr_t;

	typedef struct packed {
		logic  write;
		word_t addr;
		word_t wdata;
	} dmem_req_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     value;
	} wb_trace_t;

	//////////////////////////////////////////////////
	// Stage payloads, valid always first
	//////////////////////////////////////////////////

	typedef struct packed {
		logic   valid;
		instr_t instr;
		word_t  pc_plus_two;
	} if_id_t;

	typedef struct packed {
		logic   valid;
		instr_t instr;
		word_t  pc_plus_two;
		word_t  operand_a;
		word_t  operand_b;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		opcode_e   opcode;
		reg_addr_t rd;
		logic [7:0] imm8;
		word_t     pc_plus_two;
		word_t     store_data;
		word_t     alu_result;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		logic      write_enable;
		word_t     value;
	} mem_wb_t;

	//////////////////////////////////////////////////
	// Opcode classes
	//////////////////////////////////////////////////

	// Opcode bit 3 clear
	function automatic logic is_compute(input opcode_e op);
		return op < op_lw;
	endfunction

	function automatic logic is_load_class(input opcode_e op);
		return op == op_lw || op == op_lhb || op == op_llb;
	endfunction

	// RED and PADDSB sit in the compute range but never write
	function automatic logic writes_reg(input opcode_e op);
		return (is_compute(op) && op != op_red && op != op_paddsb) ||
			is_load_class(op) || op == op_pcs;
	endfunction

endpackage

// File: hw/stage_reg.sv
//////////////////////////////////////////////////
// Pipeline stage register
// Holds any packed payload whose top field is
// valid, with hold and bubble insertion
//////////////////////////////////////////////////

`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     hold,
	input  logic     bubble,
	input  payload_t d,
	output payload_t q
);

	// Valid is the first field, so the MSB of the packed payload
	always_ff @(posedge clk) begin
		if (reset) begin
			q[$bits(payload_t)-1] <= 1'b0;
		end else if (!hold) begin
			q <= d;
			// Bubble keeps the payload bits but kills valid
			if (bubble)
				q[$bits(payload_t)-1] <= 1'b0;
		end
	end

	valid_known_a: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(q[$bits(payload_t)-1]));

endmodule

// File: hw/register_file.sv
//////////////////////////////////////////////////
// Register file
// Sixteen words, register 0 hardwired to zero,
// writeback value bypassed to both read ports
//////////////////////////////////////////////////

`timescale 1ns/1ps

module register_file (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::reg_addr_t read_a,
	input  cpu_pkg::reg_addr_t read_b,
	output cpu_pkg::word_t     data_a,
	output cpu_pkg::word_t     data_b,
	input  cpu_pkg::mem_wb_t   write
);

	cpu_pkg::word_t regs [2**cpu_pkg::reg_addr_width];
	logic           write_active;

	// Writes to register 0 are dropped here
	assign write_active = write.valid && write.write_enable && write.rd != '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**cpu_pkg::reg_addr_width; i++)
				regs[i] <= '0;
		end else if (write_active) begin
			regs[write.rd] <= write.value;
		end
	end

	// Zero register first, then same-cycle bypass, then storage
	function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (write_active && write.rd == addr)
			return write.value;
		return regs[addr];
	endfunction

	always_comb begin
		data_a = read_port(read_a);
		data_b = read_port(read_b);
	end

endmodule

// File: hw/alu.sv
//////////////////////////////////////////////////
// ALU
// Add, subtract, xor, shifts and rotate by a
// 4-bit immediate, plus LW/SW address generation
//////////////////////////////////////////////////

`timescale 1ns/1ps

module alu (
	input  cpu_pkg::opcode_e opcode,
	input  cpu_pkg::word_t   operand_a,
	input  cpu_pkg::word_t   operand_b,
	input  logic [3:0]       imm4,
	output cpu_pkg::word_t   result
);

	cpu_pkg::word_t                    offset;
	logic [2*cpu_pkg::data_width-1:0] doubled;

	// Word offset, sign extended then shifted left by one
	assign offset = {{(cpu_pkg::data_width-5){imm4[3]}}, imm4, 1'b0};

	// Rotate right falls out of the low half of a doubled word
	assign doubled = {operand_a, operand_a} >> imm4;

	always_comb begin
		unique case (opcode)
			cpu_pkg::op_add:
				result = operand_a + operand_b;
			cpu_pkg::op_sub:
				result = operand_a - operand_b;
			cpu_pkg::op_xor:
				result = operand_a ^ operand_b;
			cpu_pkg::op_sll:
				result = operand_a << imm4;
			cpu_pkg::op_sra:
				result = $signed(operand_a) >>> imm4;
			cpu_pkg::op_ror:
				result = doubled[cpu_pkg::data_width-1:0];
			// Base plus offset for both memory ops
			cpu_pkg::op_lw,
			cpu_pkg::op_sw:
				result = operand_a + offset;
			default:
				result = '0;
		endcase
	end

endmodule

// File: hw/decode_stage.sv
//////////////////////////////////////////////////
// Decode stage
// Register read with forwarding from execute and
// memory, and the two-cycle load-class stall
//////////////////////////////////////////////////

`timescale 1ns/1ps

module decode_stage (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::if_id_t    if_id,
	input  cpu_pkg::ex_mem_t   ex_fwd,
	input  cpu_pkg::mem_wb_t   mem_fwd,
	input  cpu_pkg::mem_wb_t   wb,
	output cpu_pkg::id_ex_t    id_ex,
	output logic               load_stall
);

	cpu_pkg::reg_addr_t src_a;
	cpu_pkg::reg_addr_t src_b;
	cpu_pkg::word_t     file_a;
	cpu_pkg::word_t     file_b;
	logic               ex_hit;
	logic               mem_hit;
	logic               ex_load;
	logic               mem_load;

	// rs always feeds A
	// B is rt for compute, rd for SW, LHB and LLB
	assign src_a = if_id.instr.rs;
	assign src_b = cpu_pkg::is_compute(if_id.instr.opcode) ? if_id.instr.rt : if_id.instr.rd;

	register_file register_file_i (
		.clk    (clk),
		.reset  (reset),
		.read_a (src_a),
		.read_b (src_b),
		.data_a (file_a),
		.data_b (file_b),
		.write  (wb)
	);

	//////////////////////////////////////////////////
	// Forwarding
	//////////////////////////////////////////////////

	// Execute only has a usable result for compute ops
	assign ex_hit = ex_fwd.valid && cpu_pkg::is_compute(ex_fwd.opcode) &&
		cpu_pkg::writes_reg(ex_fwd.opcode);
	assign mem_hit = mem_fwd.valid && mem_fwd.write_enable;

	function automatic cpu_pkg::word_t pick(input cpu_pkg::reg_addr_t src,
		input cpu_pkg::word_t file_value);
		if (src != '0 && ex_hit && ex_fwd.rd == src)
			return ex_fwd.alu_result;
		if (src != '0 && mem_hit && mem_fwd.rd == src)
			return mem_fwd.value;
		return file_value;
	endfunction

	always_comb begin
		id_ex.valid       = if_id.valid;
		id_ex.instr       = if_id.instr;
		id_ex.pc_plus_two = if_id.pc_plus_two;
		id_ex.operand_a   = pick(src_a, file_a);
		id_ex.operand_b   = pick(src_b, file_b);
	end

	//////////////////////////////////////////////////
	// Load-class stall
	//////////////////////////////////////////////////

	assign ex_load = ex_fwd.valid && cpu_pkg::is_load_class(ex_fwd.opcode);

	// Execute never holds, so its contents reach memory next cycle
	always_ff @(posedge clk) begin
		if (reset)
			mem_load <= 1'b0;
		else
			mem_load <= ex_load;
	end

	assign load_stall = ex_load || mem_load;

	stall_max_two_a: assert property (@(posedge clk) disable iff (reset)
		load_stall && $past(load_stall) |=> !load_stall);

endmodule

// File: hw/mem_stage.sv
//////////////////////////////////////////////////
// Memory stage
// Drives the data memory request and picks the
// value written back to the register file
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_stage (
	input  cpu_pkg::ex_mem_t  ex_mem,
	input  logic              halted,
	input  cpu_pkg::word_t    dmem_rdata,
	output cpu_pkg::dmem_req_t dmem_req,
	output cpu_pkg::mem_wb_t  mem_wb
);

	// Store only for a live SW before halt
	always_comb begin
		dmem_req.write = ex_mem.valid && ex_mem.opcode == cpu_pkg::op_sw && !halted;
		dmem_req.addr  = ex_mem.alu_result;
		dmem_req.wdata = ex_mem.store_data;
	end

	// store_data carries the old rd value for LHB and LLB
	always_comb begin
		mem_wb.valid        = ex_mem.valid;
		mem_wb.rd           = ex_mem.rd;
		mem_wb.write_enable = cpu_pkg::writes_reg(ex_mem.opcode);
		unique case (ex_mem.opcode)
			cpu_pkg::op_lw:
				mem_wb.value = dmem_rdata;
			cpu_pkg::op_lhb:
				mem_wb.value = {ex_mem.imm8, ex_mem.store_data[7:0]};
			cpu_pkg::op_llb:
				mem_wb.value = {ex_mem.store_data[15:8], ex_mem.imm8};
			cpu_pkg::op_pcs:
				mem_wb.value = ex_mem.pc_plus_two;
			default:
				mem_wb.value = ex_mem.alu_result;
		endcase
	end

endmodule

// File: hw/cpu.sv
//////////////////////////////////////////////////
// CPU top level
// Five-stage in-order 16-bit pipeline with PC,
// fetch, sticky halt and the stage registers
// Memories sit outside and answer same cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu (
	input  logic                clk,
	input  logic                reset,
	output cpu_pkg::word_t      imem_addr,
	input  cpu_pkg::instr_t     instr,
	output cpu_pkg::dmem_req_t  dmem_req,
	input  cpu_pkg::word_t      dmem_rdata,
	output cpu_pkg::wb_trace_t  wb_trace,
	output logic                hlt
);

	cpu_pkg::word_t   pc;
	logic             pc_hold;
	logic             load_stall;
	logic             wb_hlt;
	logic             halt_q;

	cpu_pkg::if_id_t  if_id_d;
	cpu_pkg::if_id_t  if_id_q;
	cpu_pkg::id_ex_t  id_ex_d;
	cpu_pkg::id_ex_t  id_ex_q;
	cpu_pkg::ex_mem_t ex_mem_d;
	cpu_pkg::ex_mem_t ex_mem_q;
	cpu_pkg::mem_wb_t mem_wb_d;
	cpu_pkg::mem_wb_t mem_wb_q;
	cpu_pkg::mem_wb_t wb_commit;
	cpu_pkg::word_t   alu_result;

	//////////////////////////////////////////////////
	// Fetch
	//////////////////////////////////////////////////

	// PC stops on a fetched HLT and behind load-class ops
	assign pc_hold = load_stall || instr.opcode == cpu_pkg::op_hlt;

	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (!pc_hold)
			pc <= pc + cpu_pkg::word_t'(2);
	end

	assign imem_addr = pc;

	always_comb begin
		if_id_d.valid       = 1'b1;
		if_id_d.instr       = instr;
		if_id_d.pc_plus_two = pc + cpu_pkg::word_t'(2);
	end

	stage_reg #(.payload_t(cpu_pkg::if_id_t)) if_id_reg_i (
		.clk    (clk),
		.reset  (reset),
		.hold   (load_stall),
		.bubble (1'b0),
		.d      (if_id_d),
		.q      (if_id_q)
	);

	// Decode and writeback share the register file
	decode_stage decode_stage_i (
		.clk        (clk),
		.reset      (reset),
		.if_id      (if_id_q),
		.ex_fwd     (ex_mem_d),
		.mem_fwd    (mem_wb_d),
		.wb         (wb_commit),
		.id_ex      (id_ex_d),
		.load_stall (load_stall)
	);

	// Stalled decode sends a bubble down
	stage_reg #(.payload_t(cpu_pkg::id_ex_t)) id_ex_reg_i (
		.clk    (clk),
		.reset  (reset),
		.hold   (1'b0),
		.bubble (load_stall),
		.d      (id_ex_d),
		.q      (id_ex_q)
	);

	//////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////

	alu alu_i (
		.opcode    (id_ex_q.instr.opcode),
		.operand_a (id_ex_q.operand_a),
		.operand_b (id_ex_q.operand_b),
		.imm4      (id_ex_q.instr.rt),
		.result    (alu_result)
	);

	always_comb begin
		ex_mem_d.valid       = id_ex_q.valid;
		ex_mem_d.opcode      = id_ex_q.instr.opcode;
		ex_mem_d.rd          = id_ex_q.instr.rd;
		ex_mem_d.imm8        = {id_ex_q.instr.rs, id_ex_q.instr.rt};
		ex_mem_d.pc_plus_two = id_ex_q.pc_plus_two;
		ex_mem_d.store_data  = id_ex_q.operand_b;
		ex_mem_d.alu_result  = alu_result;
	end

	stage_reg #(.payload_t(cpu_pkg::ex_mem_t)) ex_mem_reg_i (
		.clk    (clk),
		.reset  (reset),
		.hold   (1'b0),
		.bubble (1'b0),
		.d      (ex_mem_d),
		.q      (ex_mem_q)
	);

	//////////////////////////////////////////////////
	// Memory and writeback
	//////////////////////////////////////////////////

	mem_stage mem_stage_i (
		.ex_mem     (ex_mem_q),
		.halted     (hlt),
		.dmem_rdata (dmem_rdata),
		.dmem_req   (dmem_req),
		.mem_wb     (mem_wb_d)
	);

	stage_reg #(.payload_t(cpu_pkg::mem_wb_t)) mem_wb_reg_i (
		.clk    (clk),
		.reset  (reset),
		.hold   (1'b0),
		.bubble (1'b0),
		.d      (mem_wb_d),
		.q      (mem_wb_q)
	);

	// mem_wb_t drops the opcode, so track a live HLT alongside it
	// Sticky halt keeps hlt up until reset
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_hlt <= 1'b0;
			halt_q <= 1'b0;
		end else begin
			wb_hlt <= ex_mem_q.valid && ex_mem_q.opcode == cpu_pkg::op_hlt;
			if (wb_hlt)
				halt_q <= 1'b1;
		end
	end

	assign hlt = halt_q || wb_hlt;

	// Nothing commits once halted
	always_comb begin
		wb_commit       = mem_wb_q;
		wb_commit.valid = mem_wb_q.valid && !hlt;
	end

	always_comb begin
		wb_trace.valid = wb_commit.valid && wb_commit.write_enable;
		wb_trace.rd    = wb_commit.rd;
		wb_trace.value = wb_commit.value;
	end

	pc_even_a: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0);

endmodule

// File: dv/cpu_tb.sv
//////////////////////////////////////////////////
// CPU testbench
// Random programs run through the pipeline and
// through a reference interpreter, writebacks
// and stores compared in order
//////////////////////////////////////////////////

`timescale 1ns/1ps

module cpu_tb;

	localparam int prog_len  = 40;
	localparam int num_runs  = 6;
	// Worst case is a load-class op in every slot
	localparam int run_limit = prog_len * 3 + 30;
	// Fetch parks on the HLT at the end of every program
	localparam cpu_pkg::word_t halt_pc = cpu_pkg::word_t'(2 * (prog_len - 1));

	// Kept instruction set, HLT only ends a program
	localparam cpu_pkg::opcode_e kept_ops [11] = '{
		cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_xor, cpu_pkg::op_sll,
		cpu_pkg::op_sra, cpu_pkg::op_ror, cpu_pkg::op_lw, cpu_pkg::op_sw,
		cpu_pkg::op_lhb, cpu_pkg::op_llb, cpu_pkg::op_pcs
	};

	logic               clk;
	logic               reset;
	cpu_pkg::word_t     imem_addr;
	cpu_pkg::instr_t    instr;
	cpu_pkg::dmem_req_t dmem_req;
	cpu_pkg::word_t     dmem_rdata;
	cpu_pkg::wb_trace_t wb_trace;
	logic               hlt;

	cpu_pkg::instr_t    imem [64];
	// Data region is 256 words, address bits 8:1
	cpu_pkg::word_t     dmem [256];
	cpu_pkg::wb_trace_t exp_trace [$];
	cpu_pkg::dmem_req_t exp_store [$];
	int                 run_cycles;
	logic               halt_seen;

	cpu dut_i (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.instr      (instr),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata),
		.wb_trace   (wb_trace),
		.hlt        (hlt)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	//////////////////////////////////////////////////
	// Memories, same-cycle read
	//////////////////////////////////////////////////

	assign instr      = imem[imem_addr[6:1]];
	assign dmem_rdata = dmem[dmem_req.addr[8:1]];

	function automatic cpu_pkg::word_t fill_value(input cpu_pkg::word_t addr);
		return {addr[7:0], addr[15:8]} ^ 16'h5ac3;
	endfunction

	// Refilled on every reset so each run starts clean
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 256; i++)
				dmem[i] <= fill_value({7'b0, i[7:0], 1'b0});
		end else if (dmem_req.write) begin
			dmem[dmem_req.addr[8:1]] <= dmem_req.wdata;
		end
	end

	//////////////////////////////////////////////////
	// Program generation and reference model
	//////////////////////////////////////////////////

	// Sources r0-r7, destinations r0-r6, r7 is the memory base
	// PCS writes r8-r15 so its result is never read back
	function automatic cpu_pkg::instr_t random_instr();
		cpu_pkg::instr_t ins;
		logic [31:0]     r;
		int              sel;
		r          = $urandom;
		sel        = r[31:24] % 11;
		ins.opcode = kept_ops[sel];
		ins.rd     = cpu_pkg::reg_addr_t'(r[7:0] % 7);
		ins.rs     = {1'b0, r[10:8]};
		ins.rt     = {1'b0, r[14:12]};
		case (ins.opcode)
			cpu_pkg::op_sll, cpu_pkg::op_sra, cpu_pkg::op_ror:
				ins.rt = r[19:16];
			cpu_pkg::op_lw: begin
				ins.rs = 4'd7;
				ins.rt = r[19:16];
			end
			cpu_pkg::op_sw: begin
				ins.rs = 4'd7;
				ins.rt = r[19:16];
				ins.rd = {1'b0, r[22:20]};
			end
			cpu_pkg::op_lhb, cpu_pkg::op_llb:
				{ins.rs, ins.rt} = r[23:16];
			cpu_pkg::op_pcs:
				ins.rd = {1'b1, r[22:20]};
			default: ;
		endcase
		return ins;
	endfunction

	task automatic make_program(input int run);
		cpu_pkg::instr_t ins;
		logic [7:0]      base_low;
		// Live instructions also sit past the HLT and must never run
		for (int i = 2; i < 64; i++)
			imem[i] = random_instr();
		ins              = '0;
		ins.opcode       = cpu_pkg::op_hlt;
		imem[prog_len-1] = ins;
		// Base register r7 = 0x01xx, offsets stay inside the region
		base_low          = 8'(32 * run);
		ins.opcode        = cpu_pkg::op_llb;
		ins.rd            = 4'd7;
		{ins.rs, ins.rt}  = base_low;
		imem[0]           = ins;
		ins.opcode        = cpu_pkg::op_lhb;
		{ins.rs, ins.rt}  = 8'h01;
		imem[1]           = ins;
	endtask

	// Architectural interpreter, one instruction at a time
	function automatic void build_expected();
		cpu_pkg::word_t     regs [16];
		cpu_pkg::word_t     mem [256];
		cpu_pkg::instr_t    ins;
		cpu_pkg::word_t     a;
		cpu_pkg::word_t     addr;
		cpu_pkg::word_t     value;
		logic               does_write;
		cpu_pkg::wb_trace_t tr;
		cpu_pkg::dmem_req_t st;
		for (int r = 0; r < 16; r++)
			regs[r] = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_value({7'b0, i[7:0], 1'b0});
		exp_trace.delete();
		exp_store.delete();
		for (int i = 0; i < prog_len; i++) begin
			ins = imem[i];
			if (ins.opcode == cpu_pkg::op_hlt)
				break;
			a          = regs[ins.rs];
			// Offset counts signed words
			addr       = a + cpu_pkg::word_t'(2 * $signed(ins.rt));
			value      = '0;
			does_write = 1'b1;
			case (ins.opcode)
				cpu_pkg::op_add: value = a + regs[ins.rt];
				cpu_pkg::op_sub: value = a - regs[ins.rt];
				cpu_pkg::op_xor: value = a ^ regs[ins.rt];
				cpu_pkg::op_sll: value = a << ins.rt;
				cpu_pkg::op_sra: value = a[15] ? ~(~a >> ins.rt) : a >> ins.rt;
				cpu_pkg::op_ror: value = (a >> ins.rt) | (a << (5'd16 - {1'b0, ins.rt}));
				cpu_pkg::op_lw:  value = mem[addr[8:1]];
				cpu_pkg::op_lhb: value = {ins.rs, ins.rt, regs[ins.rd][7:0]};
				cpu_pkg::op_llb: value = {regs[ins.rd][15:8], ins.rs, ins.rt};
				cpu_pkg::op_pcs: value = cpu_pkg::word_t'(2 * i + 2);
				cpu_pkg::op_sw: begin
					does_write = 1'b0;
					st.write   = 1'b1;
					st.addr    = addr;
					st.wdata   = regs[ins.rd];
					exp_store.push_back(st);
					mem[addr[8:1]] = regs[ins.rd];
				end
				default: does_write = 1'b0;
			endcase
			// Register 0 still shows up on the trace
			if (does_write) begin
				tr.valid = 1'b1;
				tr.rd    = ins.rd;
				tr.value = value;
				exp_trace.push_back(tr);
				if (ins.rd != '0)
					regs[ins.rd] = value;
			end
		end
	endfunction

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "Simulation stopped on the first mismatch");
	endtask

	task automatic check_trace(input cpu_pkg::wb_trace_t actual,
		input cpu_pkg::wb_trace_t expected);
		if (actual !== expected)
			abort_run($sformatf("Error at %0t: wb_trace rd %0d value %h, expected rd %0d value %h",
				$time, actual.rd, actual.value, expected.rd, expected.value));
	endtask

	task automatic check_store(input cpu_pkg::dmem_req_t actual,
		input cpu_pkg::dmem_req_t expected);
		if (actual !== expected)
			abort_run($sformatf("Error at %0t: dmem_req addr %h data %h, expected addr %h data %h",
				$time, actual.addr, actual.wdata, expected.addr, expected.wdata));
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t actual,
		input cpu_pkg::word_t expected);
		if (actual !== expected)
			abort_run($sformatf("Error at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			abort_run($sformatf("Error at %0t: %s is %b, expected %b",
				$time, name, actual, expected));
	endtask

	// Outputs settle after the rising edge, sampled on the falling one
	always @(negedge clk) begin
		if (reset) begin
			halt_seen <= 1'b0;
		end else if (halt_seen) begin
			if (wb_trace.valid || dmem_req.write)
				abort_run("A writeback or store appeared after halt");
			check_bit("hlt", hlt, 1'b1);
			check_word("imem_addr", imem_addr, halt_pc);
		end else begin
			if (wb_trace.valid) begin
				if (exp_trace.size() == 0)
					abort_run("Writeback strobe with no writeback left to expect");
				else
					check_trace(wb_trace, exp_trace.pop_front());
			end
			if (dmem_req.write) begin
				if (exp_store.size() == 0)
					abort_run("Store strobe with no store left to expect");
				else
					check_store(dmem_req, exp_store.pop_front());
			end
			if (hlt) begin
				if (exp_trace.size() != 0 || exp_store.size() != 0)
					abort_run("hlt rose before every expected writeback and store appeared");
				halt_seen <= 1'b1;
			end
		end
	end

	// Cycle budget per run, cleared by reset and by halt
	always @(posedge clk) begin
		if (reset || hlt)
			run_cycles <= 0;
		else if (run_cycles == run_limit)
			abort_run("Run hung, hlt never rose within the cycle budget");
		else
			run_cycles <= run_cycles + 1;
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		void'($urandom(32'hba3d_3486));
		for (int run = 0; run < num_runs; run++) begin
			reset = 1'b1;
			make_program(run);
			build_expected();
			repeat (8) @(posedge clk);
			#2 reset = 1'b0;
			// State straight out of reset
			@(negedge clk);
			check_word("imem_addr", imem_addr, '0);
			check_bit("hlt", hlt, 1'b0);
			check_bit("dmem_req.write", dmem_req.write, 1'b0);
			check_bit("wb_trace.valid", wb_trace.valid, 1'b0);
			wait (hlt);
			// Let the halted pipeline sit a few cycles
			repeat (4) @(posedge clk);
			#2;
		end
		if (exp_trace.size() == 0 && exp_store.size() == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			abort_run("Expected writebacks or stores never appeared");
		end
	end

endmodule

// File: list.f
hw/cpu_pkg.sv
hw/stage_reg.sv
hw/register_file.sv
hw/alu.sv
hw/decode_stage.sv
hw/mem_stage.sv
hw/cpu.sv
dv/cpu_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module cpu_tb -o cpu_tb
	./obj_dir/cpu_tb | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
